// File: all.f
source/dmc_pkg.sv
source/dmc_timing_regs.sv
source/dmc_cmd_gen.sv
source/dmc_cmd_queue.sv
source/dmc_cmd_issue.sv
source/dmc_ctrl_top.sv
tests/dmc_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module dmc_ctrl_tb -f all.f -Mdir obj_dir -o dmc_ctrl_sim

output=$(./obj_dir/dmc_ctrl_sim)
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1

// File: source/dmc_cmd_gen.sv
module dmc_cmd_gen
  import dmc_pkg::*;
#(
  parameter int col_width_p     = 10,
  parameter int row_width_p     = 14,
  parameter int dfi_burst_len_p = 4
) (
  input  logic                                    dfi_clk_i,
  input  logic                                    dfi_clk_sync_rst_i,
  input  logic                                    req_i,
  input  logic                                    write_i,
  input  logic [col_width_p+BANK_W+row_width_p-1:0] addr_i,
  input  logic                                    ap_i,
  output logic                                    ack_o,
  input  dmc_refi_t                               trefi_i,
  input  dmc_tick_t                               tcas_i,
  input  logic                                    queue_ready_i,
  output logic                                    push_o,
  output dmc_cmd_word_t                           word_o,
  output logic                                    init_calib_complete_o
);

  // Mode register burst length code, memory burst is two beats per DFI cycle
  localparam logic [3:0] burst_code_lp = 4'($clog2(2 * dfi_burst_len_p));

  dmc_seq_state_e              state_q, state_d;
  logic [2:0]                  step_q;
  logic [col_width_p-1:0]      col;
  dmc_bank_t                   bank;
  logic [row_width_p-1:0]      row;
  dmc_dfi_addr_t               col_ext;
  logic [2**BANK_W-1:0]        open_bank_q;
  logic [row_width_p-1:0]      open_row_q [2**BANK_W];
  dmc_refi_t                   refi_cnt_q;
  logic                        refr_req_q;
  logic                        last_push;
  dmc_cmd_e                    cmd;
  dmc_bank_t                   cmd_bank;
  dmc_dfi_addr_t               cmd_addr;

  assign col     = addr_i[col_width_p-1:0];
  assign bank    = addr_i[col_width_p +: BANK_W];
  assign row     = addr_i[col_width_p+BANK_W +: row_width_p];
  assign col_ext = dmc_dfi_addr_t'(col);

  // step_q counts the commands still to push in the current state
  always_comb begin
    cmd      = NOP;
    cmd_bank = '0;
    cmd_addr = '0;
    case (state_q)
      INIT: begin
        case (step_q)
          3'd5: cmd = NOP;
          3'd4: begin
            cmd      = PRE;
            cmd_addr = 16'h0400;
          end
          3'd3, 3'd2: cmd = REF;
          3'd1: begin
            cmd      = LMR;
            cmd_addr = {8'h00, tcas_i[3:0], burst_code_lp};
          end
          default: begin
            cmd      = LMR;
            cmd_bank = 3'd2;
          end
        endcase
      end
      REFR: begin
        cmd      = (step_q != 3'd0) ? PRE : REF;
        cmd_addr = (step_q != 3'd0) ? 16'h0400 : 16'h0000;
      end
      LDST: begin
        cmd_bank = bank;
        case (step_q)
          3'd2: cmd = PRE;
          3'd1: begin
            cmd      = ACT;
            cmd_addr = dmc_dfi_addr_t'(row);
          end
          default: begin
            cmd      = write_i ? WRITE : READ;
            cmd_addr = {col_ext[14:10], ap_i, col_ext[9:0]};
          end
        endcase
      end
      default: ;
    endcase
  end

  assign push_o    = queue_ready_i && (state_q != IDLE);
  assign last_push = push_o && (step_q == 3'd0);
  assign word_o    = {cmd, 1'b0, cmd_bank, cmd_addr};

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (!init_calib_complete_o) begin
          state_d = INIT;
        end else if (refr_req_q) begin
          state_d = REFR;
        end else if (req_i && !ack_o) begin
          state_d = LDST;
        end
      end
      default: begin
        if (last_push) begin
          state_d = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      state_q <= IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE) begin
        case (state_d)
          INIT: step_q <= 3'd5;
          REFR: step_q <= (|open_bank_q) ? 3'd1 : 3'd0;
          // Row hit, row conflict or closed bank
          LDST: begin
            if (open_bank_q[bank] && open_row_q[bank] == row) begin
              step_q <= 3'd0;
            end else begin
              step_q <= open_bank_q[bank] ? 3'd2 : 3'd1;
            end
          end
          default: step_q <= '0;
        endcase
      end else if (push_o && step_q != 3'd0) begin
        step_q <= step_q - 3'd1;
      end
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      init_calib_complete_o <= 1'b0;
      ack_o                 <= 1'b0;
      refr_req_q            <= 1'b0;
      refi_cnt_q            <= '0;
      open_bank_q           <= '0;
    end else begin
      if (state_q == INIT && last_push) begin
        init_calib_complete_o <= 1'b1;
      end
      if (state_q == LDST && last_push) begin
        ack_o <= 1'b1;
      end else if (!req_i) begin
        ack_o <= 1'b0;
      end
      // Interval counter stops while a refresh waits
      if (state_q == REFR && last_push) begin
        refr_req_q <= 1'b0;
      end else if (init_calib_complete_o && !refr_req_q) begin
        if (refi_cnt_q >= trefi_i) begin
          refr_req_q <= 1'b1;
          refi_cnt_q <= '0;
        end else begin
          refi_cnt_q <= refi_cnt_q + 16'd1;
        end
      end
      if (push_o) begin
        case (cmd)
          ACT: open_bank_q[cmd_bank] <= 1'b1;
          READ, WRITE: begin
            if (cmd_addr[10]) begin
              open_bank_q[cmd_bank] <= 1'b0;
            end
          end
          PRE: begin
            if (cmd_addr[10]) begin
              open_bank_q <= '0;
            end else begin
              open_bank_q[cmd_bank] <= 1'b0;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (push_o && cmd == ACT) begin
      open_row_q[cmd_bank] <= row;
    end
  end

endmodule

// File: source/dmc_cmd_issue.sv
module dmc_cmd_issue
  import dmc_pkg::*;
#(
  parameter int dfi_burst_len_p = 4
) (
  input  logic          dfi_clk_i,
  input  logic          dfi_clk_sync_rst_i,
  input  logic          head_valid_i,
  input  dmc_cmd_word_t head_word_i,
  output logic          pop_o,
  input  dmc_tick_t     tmrd_i,
  input  dmc_tick_t     trfc_i,
  input  dmc_tick_t     trp_i,
  input  dmc_tick_t     tras_i,
  input  dmc_tick_t     trrd_i,
  input  dmc_tick_t     trcd_i,
  input  dmc_tick_t     twr_i,
  input  dmc_tick_t     twtr_i,
  input  dmc_tick_t     trtp_i,
  input  dmc_tick_t     trc_i,
  input  dmc_tick_t     tcas_i,
  output logic          dfi_cke_o,
  output logic          dfi_cs_n_o,
  output logic          dfi_ras_n_o,
  output logic          dfi_cas_n_o,
  output logic          dfi_we_n_o,
  output dmc_bank_t     dfi_bank_o,
  output dmc_dfi_addr_t dfi_address_o,
  output logic          dfi_rddata_en_o,
  output logic          dfi_wrdata_en_o
);

  localparam dmc_tick_t  bl_ticks_lp = dmc_tick_t'(dfi_burst_len_p);
  localparam logic [3:0] bl_last_lp  = 4'(dfi_burst_len_p - 1);

  dmc_cmd_e   head_cmd;
  dmc_cmd_e   prev_cmd_q;
  dmc_tick_t  tick_q [4];
  logic [3:0] tick_clr;
  dmc_tick_t  cmd_tick;
  dmc_tick_t  act_tick;
  dmc_tick_t  wr_tick;
  dmc_tick_t  rd_tick;
  logic       prev_ok;
  logic       rule_ok;
  logic       issue;
  logic [15:0] rd_pipe_q;
  logic [3:0] cas_idx;
  logic       wr_start_q;
  logic [1:0] win_start;
  logic [1:0] win_en_q;
  logic [3:0] win_cnt_q [2];

  assign head_cmd = dmc_cmd_e'(head_word_i[23:20]);
  assign cmd_tick = tick_q[0];
  assign act_tick = tick_q[1];
  assign wr_tick  = tick_q[2];
  assign rd_tick  = tick_q[3];

  // Spacing after the command issued just before
  always_comb begin
    case (prev_cmd_q)
      LMR:     prev_ok = cmd_tick >= tmrd_i;
      REF:     prev_ok = cmd_tick >= trfc_i;
      PRE:     prev_ok = cmd_tick >= trp_i && (head_cmd != ACT || act_tick >= tras_i);
      default: prev_ok = 1'b1;
    endcase
  end

  // Spacing from the last ACT, WRITE and READ
  always_comb begin
    case (head_cmd)
      PRE:     rule_ok = act_tick >= tras_i && wr_tick >= twr_i && rd_tick >= trtp_i;
      ACT:     rule_ok = act_tick >= trrd_i && act_tick >= trc_i;
      WRITE:   rule_ok = act_tick >= trcd_i && wr_tick >= bl_ticks_lp && rd_tick >= bl_ticks_lp;
      READ:    rule_ok = act_tick >= trcd_i && wr_tick >= twtr_i
                         && wr_tick >= bl_ticks_lp && rd_tick >= bl_ticks_lp;
      default: rule_ok = 1'b1;
    endcase
  end

  assign issue = head_valid_i && prev_ok && rule_ok;
  assign pop_o = issue;

  assign tick_clr = {issue && head_cmd == READ, issue && head_cmd == WRITE,
                     issue && head_cmd == ACT, issue};

  // Counters saturate, reset means the last command is long past
  always_ff @(posedge dfi_clk_i) begin
    for (int i = 0; i < 4; i++) begin
      if (dfi_clk_sync_rst_i) begin
        tick_q[i] <= '1;
      end else if (tick_clr[i]) begin
        tick_q[i] <= 8'd1;
      end else if (tick_q[i] != '1) begin
        tick_q[i] <= tick_q[i] + 8'd1;
      end
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      prev_cmd_q <= NOP;
      dfi_cke_o  <= 1'b0;
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= NOP;
    end else if (issue) begin
      prev_cmd_q <= head_cmd;
      dfi_cke_o  <= 1'b1;
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= head_cmd;
    end else begin
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= NOP;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (issue) begin
      dfi_bank_o    <= head_word_i[18:16];
      dfi_address_o <= head_word_i[15:0];
    end
  end

  // Read start is delayed by CAS latency, write start by one cycle
  assign cas_idx   = tcas_i[3:0] - 4'd1;
  assign win_start = {wr_start_q, rd_pipe_q[cas_idx]};

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      rd_pipe_q  <= '0;
      wr_start_q <= 1'b0;
    end else begin
      rd_pipe_q  <= {rd_pipe_q[14:0], issue && head_cmd == READ};
      wr_start_q <= issue && head_cmd == WRITE;
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (dfi_clk_sync_rst_i) begin
        win_en_q[i]  <= 1'b0;
        win_cnt_q[i] <= '0;
      end else if (win_start[i]) begin
        win_en_q[i]  <= 1'b1;
        win_cnt_q[i] <= bl_last_lp;
      end else if (win_cnt_q[i] != 4'd0) begin
        win_cnt_q[i] <= win_cnt_q[i] - 4'd1;
      end else begin
        win_en_q[i] <= 1'b0;
      end
    end
  end

  assign dfi_rddata_en_o = win_en_q[0];
  assign dfi_wrdata_en_o = win_en_q[1];

endmodule

// File: source/dmc_cmd_queue.sv
module dmc_cmd_queue
  import dmc_pkg::*;
(
  input  logic          dfi_clk_i,
  input  logic          dfi_clk_sync_rst_i,
  input  logic          push_i,
  input  dmc_cmd_word_t word_i,
  output logic          ready_o,
  output logic          valid_o,
  output dmc_cmd_word_t word_o,
  input  logic          pop_i
);

  dmc_cmd_word_t mem_q [4];
  logic [1:0]    wr_ptr_q;
  logic [1:0]    rd_ptr_q;
  logic [2:0]    count_q;

  assign ready_o = (count_q != 3'd4);
  assign valid_o = (count_q != 3'd0);
  assign word_o  = mem_q[rd_ptr_q];

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 2'd1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 2'd1;
      end
      // Simultaneous push and pop leave the fill level unchanged
      if (push_i && !pop_i) begin
        count_q <= count_q + 3'd1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 3'd1;
      end
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= word_i;
    end
  end

endmodule

// File: source/dmc_ctrl_top.sv
module dmc_ctrl_top
  import dmc_pkg::*;
#(
  parameter int col_width_p     = 10,
  parameter int row_width_p     = 14,
  parameter int dfi_burst_len_p = 4
) (
  input  logic                                      dfi_clk_i,
  input  logic                                      dfi_clk_sync_rst_i,
  input  logic                                      req_i,
  input  logic                                      write_i,
  input  logic [col_width_p+BANK_W+row_width_p-1:0] addr_i,
  input  logic                                      ap_i,
  output logic                                      ack_o,
  input  logic                                      cfg_we_i,
  input  dmc_cfg_addr_t                             cfg_addr_i,
  input  dmc_cfg_data_t                             cfg_wdata_i,
  output logic                                      init_calib_complete_o,
  output logic                                      dfi_cke_o,
  output logic                                      dfi_cs_n_o,
  output logic                                      dfi_ras_n_o,
  output logic                                      dfi_cas_n_o,
  output logic                                      dfi_we_n_o,
  output dmc_bank_t                                 dfi_bank_o,
  output dmc_dfi_addr_t                             dfi_address_o,
  output logic                                      dfi_rddata_en_o,
  output logic                                      dfi_wrdata_en_o
);

  dmc_refi_t     trefi;
  dmc_tick_t     tmrd, trfc, trp, tras, trrd, trcd, twr, twtr, trtp, trc, tcas;
  logic          push;
  dmc_cmd_word_t push_word;
  logic          queue_ready;
  logic          head_valid;
  dmc_cmd_word_t head_word;
  logic          pop;

  dmc_timing_regs i_regs (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .cfg_we_i           (cfg_we_i),
    .cfg_addr_i         (cfg_addr_i),
    .cfg_wdata_i        (cfg_wdata_i),
    .trefi_o            (trefi),
    .tmrd_o             (tmrd),
    .trfc_o             (trfc),
    .trp_o              (trp),
    .tras_o             (tras),
    .trrd_o             (trrd),
    .trcd_o             (trcd),
    .twr_o              (twr),
    .twtr_o             (twtr),
    .trtp_o             (trtp),
    .trc_o              (trc),
    .tcas_o             (tcas)
  );

  dmc_cmd_gen #(
    .col_width_p     (col_width_p),
    .row_width_p     (row_width_p),
    .dfi_burst_len_p (dfi_burst_len_p)
  ) i_gen (
    .dfi_clk_i             (dfi_clk_i),
    .dfi_clk_sync_rst_i    (dfi_clk_sync_rst_i),
    .req_i                 (req_i),
    .write_i               (write_i),
    .addr_i                (addr_i),
    .ap_i                  (ap_i),
    .ack_o                 (ack_o),
    .trefi_i               (trefi),
    .tcas_i                (tcas),
    .queue_ready_i         (queue_ready),
    .push_o                (push),
    .word_o                (push_word),
    .init_calib_complete_o (init_calib_complete_o)
  );

  dmc_cmd_queue i_queue (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .push_i             (push),
    .word_i             (push_word),
    .ready_o            (queue_ready),
    .valid_o            (head_valid),
    .word_o             (head_word),
    .pop_i              (pop)
  );

  dmc_cmd_issue #(
    .dfi_burst_len_p (dfi_burst_len_p)
  ) i_issue (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .head_valid_i       (head_valid),
    .head_word_i        (head_word),
    .pop_o              (pop),
    .tmrd_i             (tmrd),
    .trfc_i             (trfc),
    .trp_i              (trp),
    .tras_i             (tras),
    .trrd_i             (trrd),
    .trcd_i             (trcd),
    .twr_i              (twr),
    .twtr_i             (twtr),
    .trtp_i             (trtp),
    .trc_i              (trc),
    .tcas_i             (tcas),
    .dfi_cke_o          (dfi_cke_o),
    .dfi_cs_n_o         (dfi_cs_n_o),
    .dfi_ras_n_o        (dfi_ras_n_o),
    .dfi_cas_n_o        (dfi_cas_n_o),
    .dfi_we_n_o         (dfi_we_n_o),
    .dfi_bank_o         (dfi_bank_o),
    .dfi_address_o      (dfi_address_o),
    .dfi_rddata_en_o    (dfi_rddata_en_o),
    .dfi_wrdata_en_o    (dfi_wrdata_en_o)
  );

endmodule

// File: source/dmc_pkg.sv
package dmc_pkg;

  localparam int BANK_W = 3;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    LMR   = 4'b0000,
    REF   = 4'b0001,
    PRE   = 4'b0010,
    ACT   = 4'b0011,
    WRITE = 4'b0100,
    READ  = 4'b0101,
    BST   = 4'b0110,
    NOP   = 4'b0111
  } dmc_cmd_e;

  typedef logic [BANK_W-1:0] dmc_bank_t;
  typedef logic [15:0]       dmc_dfi_addr_t;
  typedef logic [7:0]        dmc_tick_t;
  typedef logic [15:0]       dmc_refi_t;
  typedef logic [3:0]        dmc_cfg_addr_t;
  typedef logic [15:0]       dmc_cfg_data_t;

  // Queue entry {cmd[23:20], spare[19], bank[18:16], address[15:0]}
  typedef logic [23:0] dmc_cmd_word_t;

  typedef enum logic [1:0] {IDLE, INIT, REFR, LDST} dmc_seq_state_e;

  localparam dmc_cfg_addr_t CFG_TREFI = 4'd0;
  localparam dmc_cfg_addr_t CFG_TMRD  = 4'd1;
  localparam dmc_cfg_addr_t CFG_TRFC  = 4'd2;
  localparam dmc_cfg_addr_t CFG_TRP   = 4'd3;
  localparam dmc_cfg_addr_t CFG_TRAS  = 4'd4;
  localparam dmc_cfg_addr_t CFG_TRRD  = 4'd5;
  localparam dmc_cfg_addr_t CFG_TRCD  = 4'd6;
  localparam dmc_cfg_addr_t CFG_TWR   = 4'd7;
  localparam dmc_cfg_addr_t CFG_TWTR  = 4'd8;
  localparam dmc_cfg_addr_t CFG_TRTP  = 4'd9;
  localparam dmc_cfg_addr_t CFG_TRC   = 4'd10;
  localparam dmc_cfg_addr_t CFG_TCAS  = 4'd11;

  localparam dmc_refi_t DEF_TREFI = 16'd400;
  localparam dmc_tick_t DEF_TMRD  = 8'd2;
  localparam dmc_tick_t DEF_TRFC  = 8'd7;
  localparam dmc_tick_t DEF_TRP   = 8'd3;
  localparam dmc_tick_t DEF_TRAS  = 8'd7;
  localparam dmc_tick_t DEF_TRRD  = 8'd2;
  localparam dmc_tick_t DEF_TRCD  = 8'd3;
  localparam dmc_tick_t DEF_TWR   = 8'd3;
  localparam dmc_tick_t DEF_TWTR  = 8'd2;
  localparam dmc_tick_t DEF_TRTP  = 8'd2;
  localparam dmc_tick_t DEF_TRC   = 8'd10;
  localparam dmc_tick_t DEF_TCAS  = 8'd3;

endpackage

// File: source/dmc_timing_regs.sv
module dmc_timing_regs
  import dmc_pkg::*;
(
  input  logic          dfi_clk_i,
  input  logic          dfi_clk_sync_rst_i,
  input  logic          cfg_we_i,
  input  dmc_cfg_addr_t cfg_addr_i,
  input  dmc_cfg_data_t cfg_wdata_i,
  output dmc_refi_t     trefi_o,
  output dmc_tick_t     tmrd_o,
  output dmc_tick_t     trfc_o,
  output dmc_tick_t     trp_o,
  output dmc_tick_t     tras_o,
  output dmc_tick_t     trrd_o,
  output dmc_tick_t     trcd_o,
  output dmc_tick_t     twr_o,
  output dmc_tick_t     twtr_o,
  output dmc_tick_t     trtp_o,
  output dmc_tick_t     trc_o,
  output dmc_tick_t     tcas_o
);

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      trefi_o <= DEF_TREFI;
      tmrd_o  <= DEF_TMRD;
      trfc_o  <= DEF_TRFC;
      trp_o   <= DEF_TRP;
      tras_o  <= DEF_TRAS;
      trrd_o  <= DEF_TRRD;
      trcd_o  <= DEF_TRCD;
      twr_o   <= DEF_TWR;
      twtr_o  <= DEF_TWTR;
      trtp_o  <= DEF_TRTP;
      trc_o   <= DEF_TRC;
      tcas_o  <= DEF_TCAS;
    end else if (cfg_we_i) begin
      // Only the refresh interval uses the full write word
      case (cfg_addr_i)
        CFG_TREFI: trefi_o <= cfg_wdata_i;
        CFG_TMRD:  tmrd_o  <= cfg_wdata_i[7:0];
        CFG_TRFC:  trfc_o  <= cfg_wdata_i[7:0];
        CFG_TRP:   trp_o   <= cfg_wdata_i[7:0];
        CFG_TRAS:  tras_o  <= cfg_wdata_i[7:0];
        CFG_TRRD:  trrd_o  <= cfg_wdata_i[7:0];
        CFG_TRCD:  trcd_o  <= cfg_wdata_i[7:0];
        CFG_TWR:   twr_o   <= cfg_wdata_i[7:0];
        CFG_TWTR:  twtr_o  <= cfg_wdata_i[7:0];
        CFG_TRTP:  trtp_o  <= cfg_wdata_i[7:0];
        CFG_TRC:   trc_o   <= cfg_wdata_i[7:0];
        CFG_TCAS:  tcas_o  <= cfg_wdata_i[7:0];
        default: ;
      endcase
    end
  end

endmodule

// File: tests/dmc_ctrl_tb.sv
module dmc_ctrl_tb
  import dmc_pkg::*;
();

  localparam int col_w_lp    = 10;
  localparam int row_w_lp    = 14;
  localparam int addr_w_lp   = col_w_lp + BANK_W + row_w_lp;
  localparam int accesses_lp = 60;
  localparam int timeout_lp  = accesses_lp * 200 + 500;
  // Eight-beat memory burst, two beats per DFI cycle
  localparam logic [3:0] burst_code_lp = 4'd3;
  localparam dmc_tick_t  burst_lp      = 8'd4;
  localparam logic [row_w_lp-1:0] row_a_lp = 14'h0125;
  localparam logic [row_w_lp-1:0] row_b_lp = 14'h1a40;

  logic dfi_clk, dfi_clk_sync_rst, req, write, ap, ack, cfg_we, init_done;
  logic [addr_w_lp-1:0] addr;
  dmc_cfg_addr_t cfg_addr;
  dmc_cfg_data_t cfg_wdata;
  logic cke, cs_n, ras_n, cas_n, we_n, rd_en, wr_en;
  dmc_bank_t bank;
  dmc_dfi_addr_t address;

  int cyc = 0;
  int err_cnt = 0;
  int gap_err = 0;
  int en_err = 0;
  int checked = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int refreshes = 0;
  int last_any_cyc = -1000;
  int last_act_cyc = -1000;
  int last_wr_cyc = -1000;
  int last_rd_cyc = -1000;
  int last_ref_cyc = -1;
  dmc_cmd_e last_any_cmd = NOP;
  dmc_cmd_e mon_cmd;
  dmc_tick_t tras_v = DEF_TRAS;
  dmc_tick_t trp_v = DEF_TRP;
  logic [31:0] rd_sched = '0;
  logic [31:0] wr_sched = '0;

  // Commands seen on the DFI pins, and accesses sent but not yet checked
  dmc_cmd_e      obs_cmd [$];
  dmc_bank_t     obs_bank [$];
  dmc_dfi_addr_t obs_addr [$];
  logic [addr_w_lp-1:0] acc_addr [$];
  logic acc_wr [$];
  logic acc_ap [$];

  // Model of the open rows
  logic [7:0] open_v;
  logic [row_w_lp-1:0] row_v [8];

  dmc_ctrl_top i_dut (
    .dfi_clk_i             (dfi_clk),
    .dfi_clk_sync_rst_i    (dfi_clk_sync_rst),
    .req_i                 (req),
    .write_i               (write),
    .addr_i                (addr),
    .ap_i                  (ap),
    .ack_o                 (ack),
    .cfg_we_i              (cfg_we),
    .cfg_addr_i            (cfg_addr),
    .cfg_wdata_i           (cfg_wdata),
    .init_calib_complete_o (init_done),
    .dfi_cke_o             (cke),
    .dfi_cs_n_o            (cs_n),
    .dfi_ras_n_o           (ras_n),
    .dfi_cas_n_o           (cas_n),
    .dfi_we_n_o            (we_n),
    .dfi_bank_o            (bank),
    .dfi_address_o         (address),
    .dfi_rddata_en_o       (rd_en),
    .dfi_wrdata_en_o       (wr_en)
  );

  initial begin
    dfi_clk = 1'b0;
    forever #20 dfi_clk = ~dfi_clk;
  end

  always @(posedge dfi_clk) cyc <= cyc + 1;

  initial begin
    while (cyc < timeout_lp) @(posedge dfi_clk);
    $display("Timeout after %0d cycles, the DUT stopped making progress", cyc);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_cmd(string name, dmc_cmd_e exp_v, dmc_cmd_e act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s: expected %s actual %s", name, exp_v.name(), act_v.name());
      err_cnt++;
    end
  endtask

  task automatic check_bank(string name, dmc_bank_t exp_v, dmc_bank_t act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s: expected bank %0d actual %0d", name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_addr(string name, dmc_dfi_addr_t exp_v, dmc_dfi_addr_t act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s: expected address %h actual %h", name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_gap(string name, dmc_tick_t exp_v, dmc_tick_t act_v);
    if (act_v < exp_v) begin
      $display("Fail %s at cycle %0d: expected at least %0d actual %0d", name, cyc, exp_v, act_v);
      gap_err++;
    end
  endtask

  task automatic check_en(string name, logic exp_v, logic act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s at cycle %0d: expected %b actual %b", name, cyc, exp_v, act_v);
      en_err++;
    end
  endtask

  task automatic flag_error(string msg);
    $display("Error: %s", msg);
    err_cnt++;
  endtask

  function automatic dmc_tick_t gap_since(int then_cyc);
    int g;
    g = cyc - then_cyc;
    return (g > 255) ? 8'd255 : dmc_tick_t'(g);
  endfunction

  task automatic check_spacing(dmc_cmd_e c);
    case (last_any_cmd)
      LMR: check_gap("spacing tMRD", DEF_TMRD, gap_since(last_any_cyc));
      REF: check_gap("spacing tRFC", DEF_TRFC, gap_since(last_any_cyc));
      PRE: begin
        check_gap("spacing tRP", trp_v, gap_since(last_any_cyc));
        if (c == ACT) begin
          check_gap("spacing tRAS before ACT", tras_v, gap_since(last_act_cyc));
        end
      end
      default: ;
    endcase
    case (c)
      PRE: begin
        check_gap("spacing tRAS", tras_v, gap_since(last_act_cyc));
        check_gap("spacing tWR", DEF_TWR, gap_since(last_wr_cyc));
        check_gap("spacing tRTP", DEF_TRTP, gap_since(last_rd_cyc));
      end
      ACT: begin
        check_gap("spacing tRRD", DEF_TRRD, gap_since(last_act_cyc));
        check_gap("spacing tRC", DEF_TRC, gap_since(last_act_cyc));
      end
      READ, WRITE: begin
        check_gap("spacing tRCD", DEF_TRCD, gap_since(last_act_cyc));
        check_gap("spacing burst after WRITE", burst_lp, gap_since(last_wr_cyc));
        check_gap("spacing burst after READ", burst_lp, gap_since(last_rd_cyc));
        if (c == READ) begin
          check_gap("spacing tWTR", DEF_TWTR, gap_since(last_wr_cyc));
        end
      end
      default: ;
    endcase
  endtask

  // DFI monitor, sampled mid-cycle where the registered pins are stable
  always @(negedge dfi_clk) begin
    mon_cmd = dmc_cmd_e'({cs_n, ras_n, cas_n, we_n});
    if (!dfi_clk_sync_rst) begin
      if (mon_cmd != NOP) begin
        obs_cmd.push_back(mon_cmd);
        obs_bank.push_back(bank);
        obs_addr.push_back(address);
        check_spacing(mon_cmd);
        last_any_cmd = mon_cmd;
        last_any_cyc = cyc;
        if (mon_cmd == ACT) last_act_cyc = cyc;
        if (mon_cmd == WRITE) last_wr_cyc = cyc;
        if (mon_cmd == READ) last_rd_cyc = cyc;
        if (mon_cmd == REF) begin
          if (last_ref_cyc >= 0 && cyc - last_ref_cyc > DEF_TREFI + 100) begin
            flag_error($sformatf("refresh came %0d cycles after the one before",
                                 cyc - last_ref_cyc));
          end
          last_ref_cyc = cyc;
        end
      end
      if (mon_cmd == READ) rd_sched = rd_sched | (32'hF << DEF_TCAS);
      if (mon_cmd == WRITE) wr_sched = wr_sched | 32'h1E;
      check_en("rddata_en window", rd_sched[0], rd_en);
      check_en("wrdata_en window", wr_sched[0], wr_en);
      rd_sched = rd_sched >> 1;
      wr_sched = wr_sched >> 1;
    end
  end

  task automatic expect_one(dmc_cmd_e c, dmc_bank_t b, dmc_dfi_addr_t a, string name);
    while (obs_cmd.size() == 0) @(negedge dfi_clk);
    check_cmd(name, c, obs_cmd.pop_front());
    check_bank(name, b, obs_bank.pop_front());
    check_addr(name, a, obs_addr.pop_front());
  endtask

  // Refreshes seen ahead of the next access, PRE-all only if a bank is open
  task automatic expect_refresh();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      while (obs_cmd.size() == 0) @(negedge dfi_clk);
      if (obs_cmd[0] == REF || (obs_cmd[0] == PRE && obs_addr[0][10])) begin
        if (|open_v) expect_one(PRE, 3'd0, 16'h0400, "refresh precharge");
        expect_one(REF, 3'd0, 16'h0000, "refresh");
        open_v = '0;
        refreshes++;
      end else begin
        busy = 1'b0;
      end
    end
  endtask

  task automatic finish_test(string name, int start_err);
    tests_run++;
    if (err_cnt != start_err) tests_failed++;
    $display("%s %s", name, (err_cnt == start_err) ? "passed" : "failed");
  endtask

  initial begin
    int start_err;
    logic [addr_w_lp-1:0] a;
    logic w, p;
    dmc_bank_t bk;
    logic [row_w_lp-1:0] rw;
    logic [col_w_lp-1:0] col;
    open_v = '0;
    start_err = err_cnt;
    expect_one(PRE, 3'd0, 16'h0400, "init");
    expect_one(REF, 3'd0, 16'h0000, "init");
    expect_one(REF, 3'd0, 16'h0000, "init");
    expect_one(LMR, 3'd0, {8'h00, DEF_TCAS[3:0], burst_code_lp}, "init");
    expect_one(LMR, 3'd2, 16'h0000, "init");
    if (init_done !== 1'b1 || cke !== 1'b1) begin
      flag_error("init_calib_complete or cke is low after the init sequence");
    end
    finish_test("init", start_err);
    for (int n = 0; n < accesses_lp; n++) begin
      while (acc_addr.size() == 0) @(negedge dfi_clk);
      a = acc_addr.pop_front();
      w = acc_wr.pop_front();
      p = acc_ap.pop_front();
      col = a[col_w_lp-1:0];
      bk = a[col_w_lp +: BANK_W];
      rw = a[col_w_lp+BANK_W +: row_w_lp];
      start_err = err_cnt;
      expect_refresh();
      if (!(open_v[bk] && row_v[bk] == rw)) begin
        if (open_v[bk]) expect_one(PRE, bk, 16'h0000, $sformatf("access_%0d", n));
        expect_one(ACT, bk, dmc_dfi_addr_t'(rw), $sformatf("access_%0d", n));
        open_v[bk] = 1'b1;
        row_v[bk] = rw;
      end
      expect_one(w ? WRITE : READ, bk, {5'b0, p, col}, $sformatf("access_%0d", n));
      if (p) open_v[bk] = 1'b0;
      finish_test($sformatf("access_%0d", n), start_err);
      checked++;
    end
  end

  task automatic write_cfg(dmc_cfg_addr_t a, dmc_cfg_data_t d);
    cfg_we = 1'b1;
    cfg_addr = a;
    cfg_wdata = d;
    @(posedge dfi_clk);
    #5;
    cfg_we = 1'b0;
  endtask

  initial begin
    int sel;
    logic [addr_w_lp-1:0] a;
    logic w, p;
    dfi_clk_sync_rst = 1'b1;
    req = 1'b0;
    write = 1'b0;
    addr = '0;
    ap = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    void'($urandom(20598));
    repeat (16) @(posedge dfi_clk);
    #5;
    dfi_clk_sync_rst = 1'b0;
    for (int n = 0; n < accesses_lp; n++) begin
      if (n == accesses_lp / 2) begin
        write_cfg(CFG_TRAS, 16'd9);
        write_cfg(CFG_TRP, 16'd5);
        // Commands decided before the write are still on their way out
        repeat (2) begin
          @(posedge dfi_clk);
          #5;
        end
        tras_v = 8'd9;
        trp_v = 8'd5;
      end
      // Three banks and two rows give hits, misses and conflicts
      sel = $urandom % 3;
      a[col_w_lp-1:0] = col_w_lp'($urandom);
      a[col_w_lp +: BANK_W] = (sel == 0) ? 3'd0 : (sel == 1) ? 3'd3 : 3'd5;
      a[col_w_lp+BANK_W +: row_w_lp] = (($urandom % 2) != 0) ? row_a_lp : row_b_lp;
      w = ($urandom % 2) != 0;
      p = ($urandom % 4) == 0;
      acc_addr.push_back(a);
      acc_wr.push_back(w);
      acc_ap.push_back(p);
      req = 1'b1;
      write = w;
      addr = a;
      ap = p;
      while (ack !== 1'b1) begin
        @(posedge dfi_clk);
        #5;
      end
      req = 1'b0;
      @(posedge dfi_clk);
      #5;
      if (ack !== 1'b0) flag_error("ack did not fall one cycle after req fell");
      while (ack !== 1'b0) begin
        @(posedge dfi_clk);
        #5;
      end
      repeat ($urandom % 3) begin
        @(posedge dfi_clk);
        #5;
      end
    end
    while (checked < accesses_lp) @(posedge dfi_clk);
    repeat (20) @(posedge dfi_clk);
    if (refreshes == 0) flag_error("no periodic refresh was seen during the run");
    tests_run += 2;
    tests_failed += ((gap_err != 0) ? 1 : 0) + ((en_err != 0) ? 1 : 0);
    $display("spacing %s", (gap_err == 0) ? "passed" : "failed");
    $display("data_enables %s", (en_err == 0) ? "passed" : "failed");
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, err_cnt + gap_err + en_err);
    if (err_cnt + gap_err + en_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
